// ==== design/osr_ctrl_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface osr_ctrl_if;
    import sm_data_pkg::*;

    // Sequencer side
    logic   load;
    word_t  load_data;
    logic   shift_en;
    shcnt_t shift_count;

    // Shift unit side
    word_t  shift_out;
    logic   empty;
    word_t  osr_value;

    modport seq (
        output load, load_data, shift_en, shift_count,
        input  shift_out, empty, osr_value
    );

    modport shifter (
        input  load, load_data, shift_en, shift_count,
        output shift_out, empty, osr_value
    );

endinterface

`default_nettype wire

// ==== design/osr_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "sm_consts.svh"

module osr_unit (
    input  logic        clk,
    input  logic        rst,
    input  logic        shift_dir,
    osr_ctrl_if.shifter ctrl
);
    import sm_data_pkg::*;

    word_t                   osr;
    shcnt_t                  shift_cnt;
    word_t                   shifted;
    logic [$bits(shcnt_t):0] cnt_sum;

    assign ctrl.osr_value = osr;
    assign ctrl.empty     = (shift_cnt == shcnt_t'(`SM_WORD_W));

    // Outgoing field is always right-aligned and zero-extended
    always_comb begin
        if (shift_dir) begin
            // Right shift, low bits leave first
            ctrl.shift_out = osr & ~(word_t'('1) << ctrl.shift_count);
            shifted        = osr >> ctrl.shift_count;
        end else begin
            // Left shift, high bits leave first
            ctrl.shift_out = osr >> (shcnt_t'(`SM_WORD_W) - ctrl.shift_count);
            shifted        = osr << ctrl.shift_count;
        end
    end

    // One bit wider than the counter so the sum cannot wrap
    assign cnt_sum = shift_cnt + ctrl.shift_count;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            osr       <= '0;
            shift_cnt <= shcnt_t'(`SM_WORD_W);
        end else if (ctrl.load) begin
            osr       <= ctrl.load_data;
            shift_cnt <= '0;
        end else if (ctrl.shift_en) begin
            osr <= shifted;
            // Saturate at a full word, which reads as empty
            if (cnt_sum >= `SM_WORD_W) begin
                shift_cnt <= shcnt_t'(`SM_WORD_W);
            end else begin
                shift_cnt <= cnt_sum[$bits(shcnt_t)-1:0];
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/scratch_regs.sv ====
`timescale 1ns/10ps
`default_nettype none

module scratch_regs (
    input  logic               clk,
    input  logic               rst,
    input  logic               wr_x,
    input  logic               wr_y,
    input  sm_data_pkg::word_t wr_value,
    input  logic               dec_x,
    input  logic               dec_y,
    output sm_data_pkg::word_t x,
    output sm_data_pkg::word_t y,
    output logic               x_zero,
    output logic               y_zero,
    output logic               x_ne_y
);

    // A write wins over a decrement
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            x <= '0;
            y <= '0;
        end else begin
            if (wr_x) begin
                x <= wr_value;
            end else if (dec_x) begin
                // Wraps from zero to all ones
                x <= x - 1'b1;
            end

            if (wr_y) begin
                y <= wr_value;
            end else if (dec_y) begin
                y <= y - 1'b1;
            end
        end
    end

    // Jump condition flags, taken from the pre-decrement values
    assign x_zero = (x == '0);
    assign y_zero = (y == '0);
    assign x_ne_y = (x != y);

endmodule

`default_nettype wire

// ==== design/sm_data_pkg.sv ====
`default_nettype none

`include "sm_consts.svh"

package sm_data_pkg;

    typedef logic [`SM_WORD_W-1:0] word_t;

    // Needs to hold 0 through a full word
    typedef logic [$clog2(`SM_WORD_W+1)-1:0] shcnt_t;

    typedef logic [`SM_PC_W-1:0] pc_t;

endpackage

`default_nettype wire

// ==== design/sm_isa_pkg.sv ====
`default_nettype none

`include "sm_consts.svh"

package sm_isa_pkg;

    typedef enum logic [`SM_OP_MSB-`SM_OP_LSB:0] {
        OP_JMP       = 3'd0,
        OP_WAIT      = 3'd1,
        OP_IN        = 3'd2,
        OP_OUT       = 3'd3,
        OP_PUSH_PULL = 3'd4,
        OP_MOV       = 3'd5,
        OP_IRQ       = 3'd6,
        OP_SET       = 3'd7
    } opcode_e;

    typedef enum logic [`SM_DST_MSB-`SM_DST_LSB:0] {
        COND_ALWAYS        = 3'd0,
        COND_X_ZERO        = 3'd1,
        COND_X_DEC         = 3'd2,
        COND_Y_ZERO        = 3'd3,
        COND_Y_DEC         = 3'd4,
        COND_X_NE_Y        = 3'd5,
        COND_PIN           = 3'd6,
        COND_OSR_NOT_EMPTY = 3'd7
    } jmp_cond_e;

    // Shared by MOV destination and source fields
    typedef enum logic [`SM_DST_MSB-`SM_DST_LSB:0] {
        MOV_PINS = 3'd0,
        MOV_X    = 3'd1,
        MOV_Y    = 3'd2,
        MOV_NULL = 3'd3,
        MOV_EXEC = 3'd4,
        MOV_PC   = 3'd5,
        MOV_ISR  = 3'd6,
        MOV_OSR  = 3'd7
    } mov_opnd_e;

    typedef enum logic [`SM_DST_MSB-`SM_DST_LSB:0] {
        OUT_X    = 3'd1,
        OUT_Y    = 3'd2,
        OUT_NULL = 3'd3
    } out_dest_e;

    // Delay field sits between the opcode and the destination
    typedef struct packed {
        opcode_e                             op;
        logic [`SM_OP_LSB-`SM_DST_MSB-2:0]   delay;
        logic [`SM_DST_MSB-`SM_DST_LSB:0]    dst;
        logic [`SM_OPND_MSB-`SM_OPND_LSB:0]  operand;
    } instr_t;

endpackage

`default_nettype wire

// ==== design/sm_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "sm_consts.svh"

module sm_sequencer (
    input  logic               clk,
    input  logic               rst,
    input  sm_isa_pkg::instr_t instruction,
    output sm_data_pkg::pc_t   pc,
    output logic               fifo_pop,
    input  sm_data_pkg::word_t fifo_head,
    input  logic               fifo_not_empty,
    output logic               wr_x,
    output logic               wr_y,
    output sm_data_pkg::word_t wr_value,
    output logic               dec_x,
    output logic               dec_y,
    input  sm_data_pkg::word_t x,
    input  sm_data_pkg::word_t y,
    input  logic               x_zero,
    input  logic               y_zero,
    input  logic               x_ne_y,
    osr_ctrl_if.seq            osr,
    output sm_data_pkg::word_t rx_data,
    output logic               rx_valid,
    input  logic               rx_ready
);
    import sm_isa_pkg::*;
    import sm_data_pkg::*;

    opcode_e   op;
    jmp_cond_e cond;
    out_dest_e out_dst;
    mov_opnd_e mov_dst;
    mov_opnd_e mov_src;
    logic      pull_sel;
    logic      block;
    shcnt_t    out_count;
    logic      src_ok;
    word_t     src_value;
    logic      stall;
    logic      take_jump;
    pc_t       pc_next;

    // Field decode
    assign op       = instruction.op;
    assign cond     = jmp_cond_e'(instruction.dst);
    assign out_dst  = out_dest_e'(instruction.dst);
    assign mov_dst  = mov_opnd_e'(instruction.dst);
    assign mov_src  = mov_opnd_e'(instruction.operand[2:0]);
    assign pull_sel = instruction.dst[2];
    assign block    = instruction.dst[0];

    // OUT count of 0 means a full word
    assign out_count = (instruction.operand == '0) ? shcnt_t'(`SM_WORD_W)
                                                   : shcnt_t'(instruction.operand);

    // PUSH always offers X
    assign rx_data = x;

    // MOV source select, unsupported sources leave src_ok low
    always_comb begin
        src_ok    = 1'b1;
        src_value = '0;
        case (mov_src)
            MOV_X:    src_value = x;
            MOV_Y:    src_value = y;
            MOV_NULL: src_value = '0;
            MOV_OSR:  src_value = osr.osr_value;
            default:  src_ok = 1'b0;
        endcase
    end

    always_comb begin
        stall           = 1'b0;
        take_jump       = 1'b0;
        fifo_pop        = 1'b0;
        wr_x            = 1'b0;
        wr_y            = 1'b0;
        wr_value        = '0;
        dec_x           = 1'b0;
        dec_y           = 1'b0;
        rx_valid        = 1'b0;
        osr.load        = 1'b0;
        osr.load_data   = '0;
        osr.shift_en    = 1'b0;
        osr.shift_count = out_count;

        case (op)
            OP_JMP: begin
                case (cond)
                    COND_ALWAYS:        take_jump = 1'b1;
                    COND_X_ZERO:        take_jump = x_zero;
                    COND_X_DEC: begin
                        take_jump = !x_zero;
                        dec_x     = 1'b1;
                    end
                    COND_Y_ZERO:        take_jump = y_zero;
                    COND_Y_DEC: begin
                        take_jump = !y_zero;
                        dec_y     = 1'b1;
                    end
                    COND_X_NE_Y:        take_jump = x_ne_y;
                    COND_OSR_NOT_EMPTY: take_jump = !osr.empty;
                    default:            take_jump = 1'b0;
                endcase
            end
            OP_OUT: begin
                case (out_dst)
                    OUT_X: begin
                        osr.shift_en = 1'b1;
                        wr_x         = 1'b1;
                        wr_value     = osr.shift_out;
                    end
                    OUT_Y: begin
                        osr.shift_en = 1'b1;
                        wr_y         = 1'b1;
                        wr_value     = osr.shift_out;
                    end
                    OUT_NULL: osr.shift_en = 1'b1;
                    default: ;
                endcase
            end
            OP_PUSH_PULL: begin
                if (pull_sel) begin
                    if (fifo_not_empty) begin
                        fifo_pop      = 1'b1;
                        osr.load      = 1'b1;
                        osr.load_data = fifo_head;
                    end else if (block) begin
                        stall = 1'b1;
                    end else begin
                        // Empty FIFO without block copies X
                        osr.load      = 1'b1;
                        osr.load_data = x;
                    end
                end else begin
                    rx_valid = 1'b1;
                    // Non-blocking push just drops the value
                    stall    = block && !rx_ready;
                end
            end
            OP_MOV: begin
                case (mov_dst)
                    MOV_X: begin
                        wr_x     = src_ok;
                        wr_value = src_value;
                    end
                    MOV_Y: begin
                        wr_y     = src_ok;
                        wr_value = src_value;
                    end
                    MOV_OSR: begin
                        osr.load      = src_ok;
                        osr.load_data = src_value;
                    end
                    default: ;
                endcase
            end
            OP_SET: begin
                wr_value = word_t'(instruction.operand);
                case (mov_dst)
                    MOV_X:   wr_x = 1'b1;
                    MOV_Y:   wr_y = 1'b1;
                    default: ;
                endcase
            end
            // WAIT, IN and IRQ fall through as no-ops
            default: ;
        endcase
    end

    always_comb begin
        if (stall) begin
            pc_next = pc;
        end else if (take_jump) begin
            pc_next = pc_t'(instruction.operand);
        end else begin
            pc_next = pc + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

endmodule

`default_nettype wire

// ==== design/sm_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "sm_consts.svh"

module sm_top (
    input  logic               clk,
    input  logic               rst,
    input  sm_isa_pkg::instr_t instruction,
    output sm_data_pkg::pc_t   pc,
    input  logic               shift_dir,
    input  sm_data_pkg::word_t tx_data,
    input  logic               tx_valid,
    output logic               tx_ready,
    output sm_data_pkg::word_t rx_data,
    output logic               rx_valid,
    input  logic               rx_ready
);
    import sm_data_pkg::*;

    logic  fifo_pop;
    word_t fifo_head;
    logic  fifo_not_empty;
    logic  wr_x;
    logic  wr_y;
    word_t wr_value;
    logic  dec_x;
    logic  dec_y;
    word_t x;
    word_t y;
    logic  x_zero;
    logic  y_zero;
    logic  x_ne_y;

    osr_ctrl_if osr_if ();

    tx_fifo #(
        .DEPTH(`SM_FIFO_DEPTH)
    ) u_tx_fifo (
        .clk      (clk),
        .rst      (rst),
        .wr_data  (tx_data),
        .wr_valid (tx_valid),
        .wr_ready (tx_ready),
        .pop      (fifo_pop),
        .head     (fifo_head),
        .not_empty(fifo_not_empty)
    );

    scratch_regs u_scratch (
        .clk     (clk),
        .rst     (rst),
        .wr_x    (wr_x),
        .wr_y    (wr_y),
        .wr_value(wr_value),
        .dec_x   (dec_x),
        .dec_y   (dec_y),
        .x       (x),
        .y       (y),
        .x_zero  (x_zero),
        .y_zero  (y_zero),
        .x_ne_y  (x_ne_y)
    );

    osr_unit u_osr (
        .clk      (clk),
        .rst      (rst),
        .shift_dir(shift_dir),
        .ctrl     (osr_if.shifter)
    );

    sm_sequencer u_seq (
        .clk           (clk),
        .rst           (rst),
        .instruction   (instruction),
        .pc            (pc),
        .fifo_pop      (fifo_pop),
        .fifo_head     (fifo_head),
        .fifo_not_empty(fifo_not_empty),
        .wr_x          (wr_x),
        .wr_y          (wr_y),
        .wr_value      (wr_value),
        .dec_x         (dec_x),
        .dec_y         (dec_y),
        .x             (x),
        .y             (y),
        .x_zero        (x_zero),
        .y_zero        (y_zero),
        .x_ne_y        (x_ne_y),
        .osr           (osr_if.seq),
        .rx_data       (rx_data),
        .rx_valid      (rx_valid),
        .rx_ready      (rx_ready)
    );

endmodule

`default_nettype wire

// ==== design/tx_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "sm_consts.svh"

module tx_fifo #(
    parameter int DEPTH = `SM_FIFO_DEPTH
) (
    input  logic               clk,
    input  logic               rst,
    input  sm_data_pkg::word_t wr_data,
    input  logic               wr_valid,
    output logic               wr_ready,
    input  logic               pop,
    output sm_data_pkg::word_t head,
    output logic               not_empty
);
    import sm_data_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    word_t            mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             do_pop;

    // Wraps at DEPTH, so any depth works
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign wr_ready  = (count != CNT_W'(DEPTH));
    assign not_empty = (count != '0);
    assign push      = wr_valid && wr_ready;
    // Pop on empty is ignored
    assign do_pop    = pop && not_empty;
    assign head      = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+include
design/sm_data_pkg.sv
design/sm_isa_pkg.sv
design/osr_ctrl_if.sv
design/tx_fifo.sv
design/scratch_regs.sv
design/osr_unit.sv
design/sm_sequencer.sv
design/sm_top.sv
verif/sm_clk_gen.sv
verif/sm_chk.sv
verif/sm_tb.sv

// ==== include/sm_consts.svh ====
`ifndef SM_CONSTS_SVH
`define SM_CONSTS_SVH

// Datapath widths
`define SM_WORD_W      32
`define SM_PC_W        5

// Transmit FIFO entries
`define SM_FIFO_DEPTH  4

// Instruction fields
`define SM_OP_MSB      15
`define SM_OP_LSB      13
`define SM_DST_MSB     7
`define SM_DST_LSB     5
`define SM_OPND_MSB    4
`define SM_OPND_LSB    0

`endif

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the simulation with Verilator, pass/fail from the log
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary -sv --assert -Wno-fatal --top-module sm_tb \
    -f flist.f --Mdir "$OBJ" -o sm_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/sm_sim" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^Test completed successfully$" "$LOG"; then
    exit 0
fi
exit 1

// ==== verif/sm_chk.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "sm_consts.svh"

module sm_chk (
    input logic                clk,
    input logic                rst,
    input logic [15:0]         instruction,
    input sm_data_pkg::pc_t    pc,
    input logic                rx_valid,
    input logic                rx_ready,
    input logic                tx_valid,
    input logic                tx_ready,
    input logic                fifo_pop
);

    localparam int OCC_W = $clog2(`SM_FIFO_DEPTH + 1);

    logic [OCC_W-1:0] occupancy;
    logic             wrote;
    logic             took;

    // Occupancy seen from the tx port and the sequencer's pops
    assign wrote = tx_valid && tx_ready;
    assign took  = fifo_pop && (occupancy != '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            occupancy <= '0;
        end else begin
            occupancy <= occupancy + OCC_W'(wrote) - OCC_W'(took);
        end
    end

    // Blocking PUSH without a taker holds the program
    a_pc_hold: assert property (
        @(posedge clk) disable iff (rst)
        (rx_valid && !rx_ready && instruction[5]) |=> $stable(pc)
    ) else $error("pc moved while a blocking PUSH waited for rx_ready");

    a_tx_full: assert property (
        @(posedge clk) disable iff (rst)
        !tx_ready |-> (occupancy == `SM_FIFO_DEPTH)
    ) else $error("tx_ready low while the transmit FIFO is not full");

    a_rx_reset: assert property (
        @(posedge clk) rst |-> !rx_valid
    ) else $error("rx_valid high during reset");

endmodule

bind sm_top sm_chk chk (
    .clk        (clk),
    .rst        (rst),
    .instruction(instruction),
    .pc         (pc),
    .rx_valid   (rx_valid),
    .rx_ready   (rx_ready),
    .tx_valid   (tx_valid),
    .tx_ready   (tx_ready),
    .fifo_pop   (fifo_pop)
);

`default_nettype wire

// ==== verif/sm_clk_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module sm_clk_gen #(
    parameter int PERIOD_NS = 40
) (
    output logic clk
);

    // Free-running clock, starts low
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

endmodule

`default_nettype wire

// ==== verif/sm_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "sm_consts.svh"

module sm_tb;
    import sm_isa_pkg::*;
    import sm_data_pkg::*;

    localparam int RESET_CYCLES = 16;
    localparam int NUM_TESTS    = 6;
    localparam int BUDGET_SUM   = 80 + 100 + 100 + 100 + 100 + 80;
    // Budgets plus reset time of every test plus slack
    localparam int TIMEOUT_CYCLES = BUDGET_SUM + NUM_TESTS * (RESET_CYCLES + 2) + 100;

    localparam logic [2:0] PULL_BLK = 3'b101;
    localparam logic [2:0] PULL_NB  = 3'b100;
    localparam logic [2:0] PUSH_BLK = 3'b001;
    localparam logic [2:0] PUSH_NB  = 3'b000;

    logic        clk;
    logic        rst         = 1'b1;
    logic [15:0] instruction = '0;
    pc_t         pc;
    logic        shift_dir   = 1'b0;
    word_t       tx_data     = '0;
    logic        tx_valid    = 1'b0;
    logic        tx_ready;
    word_t       rx_data;
    logic        rx_valid;
    logic        rx_ready    = 1'b0;

    integer seed = 32'hc91f_2d94;

    // Program memory and reference model state
    logic [15:0] prog [32];
    pc_t         m_pc;
    word_t       m_x;
    word_t       m_y;
    word_t       m_osr;
    int          m_cnt;
    word_t       m_fifo [$];

    string cur_test;
    int    test_errors;
    int    total_errors = 0;
    int    tests_run    = 0;
    int    tests_failed = 0;
    int    rx_count;
    int    cycle_count  = 0;
    int    tx_start;
    int    tx_rate;
    int    rx_start;
    int    rx_rate;

    sm_clk_gen #(.PERIOD_NS(40)) clk_gen (.clk(clk));

    sm_top UUT (
        .clk        (clk),
        .rst        (rst),
        .instruction(instruction),
        .pc         (pc),
        .shift_dir  (shift_dir),
        .tx_data    (tx_data),
        .tx_valid   (tx_valid),
        .tx_ready   (tx_ready),
        .rx_data    (rx_data),
        .rx_valid   (rx_valid),
        .rx_ready   (rx_ready)
    );

    function automatic logic [15:0] make_instr(input logic [2:0] op, input logic [2:0] dst,
                                               input int opnd);
        return {op, 5'b0, dst, opnd[4:0]};
    endfunction

    task automatic put(input int addr, input logic [2:0] op, input logic [2:0] dst,
                       input int opnd);
        prog[addr] = make_instr(op, dst, opnd);
    endtask

    // Unused slots jump to themselves
    task automatic clear_prog();
        for (int a = 0; a < 32; a++) begin
            prog[a] = make_instr(OP_JMP, COND_ALWAYS, a);
        end
    endtask

    task automatic compare_value(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Mismatch in %s, %s: expected %h, actual %h",
                     cur_test, what, expected, actual);
            test_errors++;
        end
    endtask

    // One instruction of the reference model, using the inputs of the cycle
    task automatic model_step();
        logic [15:0] ins;
        logic [2:0]  op;
        logic [2:0]  dst;
        logic [4:0]  opnd;
        logic        stall;
        logic        jump;
        logic        accept;
        logic        src_ok;
        word_t       src;
        int          count;
        logic [63:0] wide;
        word_t       field;

        ins    = prog[m_pc];
        op     = ins[15:13];
        dst    = ins[7:5];
        opnd   = ins[4:0];
        stall  = 1'b0;
        jump   = 1'b0;
        src_ok = 1'b1;
        src    = '0;
        // Room is judged before this cycle's pop
        accept = tx_valid && (m_fifo.size() < `SM_FIFO_DEPTH);

        case (op)
            OP_JMP: begin
                case (dst)
                    COND_ALWAYS: jump = 1'b1;
                    COND_X_ZERO: jump = (m_x == 0);
                    COND_X_DEC: begin
                        jump = (m_x != 0);
                        m_x  = m_x - 32'd1;
                    end
                    COND_Y_ZERO: jump = (m_y == 0);
                    COND_Y_DEC: begin
                        jump = (m_y != 0);
                        m_y  = m_y - 32'd1;
                    end
                    COND_X_NE_Y:        jump = (m_x != m_y);
                    COND_OSR_NOT_EMPTY: jump = (m_cnt < 32);
                    default:            jump = 1'b0;
                endcase
            end
            OP_OUT: begin
                if (dst == OUT_X || dst == OUT_Y || dst == OUT_NULL) begin
                    count = (opnd == 0) ? 32 : int'(opnd);
                    if (shift_dir) begin
                        wide  = {32'b0, m_osr};
                        field = word_t'(wide & ((64'd1 << count) - 64'd1));
                        m_osr = word_t'(wide >> count);
                    end else begin
                        wide  = {32'b0, m_osr} << count;
                        field = wide[63:32];
                        m_osr = wide[31:0];
                    end
                    m_cnt = (m_cnt + count > 32) ? 32 : m_cnt + count;
                    if (dst == OUT_X) begin
                        m_x = field;
                    end else if (dst == OUT_Y) begin
                        m_y = field;
                    end
                end
            end
            OP_PUSH_PULL: begin
                if (dst[2]) begin
                    if (m_fifo.size() > 0) begin
                        m_osr = m_fifo.pop_front();
                        m_cnt = 0;
                    end else if (dst[0]) begin
                        stall = 1'b1;
                    end else begin
                        m_osr = m_x;
                        m_cnt = 0;
                    end
                end else begin
                    stall = dst[0] && !rx_ready;
                end
            end
            OP_MOV: begin
                case (ins[2:0])
                    MOV_X:    src = m_x;
                    MOV_Y:    src = m_y;
                    MOV_NULL: src = '0;
                    MOV_OSR:  src = m_osr;
                    default:  src_ok = 1'b0;
                endcase
                if (src_ok) begin
                    case (dst)
                        MOV_X: m_x = src;
                        MOV_Y: m_y = src;
                        MOV_OSR: begin
                            m_osr = src;
                            m_cnt = 0;
                        end
                        default: ;
                    endcase
                end
            end
            OP_SET: begin
                if (dst == MOV_X) begin
                    m_x = word_t'(opnd);
                end else if (dst == MOV_Y) begin
                    m_y = word_t'(opnd);
                end
            end
            default: ;
        endcase

        if (accept) begin
            m_fifo.push_back(tx_data);
        end
        if (!stall) begin
            m_pc = jump ? opnd : m_pc + 5'd1;
        end
    endtask

    task automatic check_outputs();
        logic exp_valid;

        exp_valid = (prog[m_pc][15:13] == OP_PUSH_PULL) && !prog[m_pc][7];
        compare_value("pc", 32'(m_pc), 32'(pc));
        compare_value("rx_valid", 32'(exp_valid), 32'(rx_valid));
        compare_value("tx_ready", 32'(m_fifo.size() < `SM_FIFO_DEPTH), 32'(tx_ready));
        if (rx_valid && rx_ready) begin
            compare_value("rx_data", m_x, rx_data);
            rx_count++;
        end
    endtask

    task automatic drive_inputs(input int cyc);
        tx_valid    <= (cyc >= tx_start) && (($random(seed) & 3) < tx_rate);
        tx_data     <= $random(seed);
        rx_ready    <= (cyc >= rx_start) && (($random(seed) & 3) < rx_rate);
        instruction <= prog[m_pc];
    endtask

    // Instruction 0 during reset is a JMP, so rx_valid stays low
    task automatic reset_dut(input logic dir);
        @(posedge clk);
        rst         <= 1'b1;
        instruction <= '0;
        tx_valid    <= 1'b0;
        rx_ready    <= 1'b0;
        shift_dir   <= dir;
        repeat (RESET_CYCLES) @(posedge clk);
        m_pc  = '0;
        m_x   = '0;
        m_y   = '0;
        m_osr = '0;
        m_cnt = 32;
        m_fifo.delete();
        rst <= 1'b0;
        drive_inputs(0);
    endtask

    task automatic run_test(input string name, input int budget, input pc_t end_pc,
                            input logic dir, input int txs, input int txr,
                            input int rxs, input int rxr);
        int   cyc;
        logic done;

        cur_test    = name;
        test_errors = 0;
        rx_count    = 0;
        tx_start    = txs;
        tx_rate     = txr;
        rx_start    = rxs;
        rx_rate     = rxr;
        reset_dut(dir);
        cyc  = 0;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            check_outputs();
            if (pc == end_pc) begin
                done = 1'b1;
            end else if (cyc >= budget) begin
                $display("Error in %s: pc did not reach %0d within %0d cycles",
                         name, end_pc, budget);
                test_errors++;
                done = 1'b1;
            end else begin
                @(posedge clk);
                model_step();
                cyc++;
                drive_inputs(cyc);
            end
        end
        $display("%s: %0d cycles, %0d results, %0d errors", name, cyc, rx_count, test_errors);
        tests_run++;
        total_errors += test_errors;
        if (test_errors != 0) begin
            tests_failed++;
        end
    endtask

    task automatic load_set_mov();
        clear_prog();
        put(0, OP_SET, MOV_X, 19);
        put(1, OP_PUSH_PULL, PUSH_BLK, 0);
        put(2, OP_SET, MOV_Y, 7);
        put(3, OP_MOV, MOV_X, MOV_Y);
        put(4, OP_PUSH_PULL, PUSH_BLK, 0);
        put(5, OP_MOV, MOV_Y, MOV_NULL);
        put(6, OP_MOV, MOV_X, MOV_Y);
        put(7, OP_PUSH_PULL, PUSH_BLK, 0);
        put(8, OP_SET, MOV_X, 31);
        put(9, OP_MOV, MOV_Y, MOV_X);
        put(10, OP_MOV, MOV_X, MOV_NULL);
        put(11, OP_MOV, MOV_X, MOV_Y);
        put(12, OP_PUSH_PULL, PUSH_BLK, 0);
        // NULL destination and PINS source do nothing
        put(13, OP_MOV, MOV_NULL, MOV_X);
        put(14, OP_MOV, MOV_X, MOV_PINS);
        put(15, OP_PUSH_PULL, PUSH_BLK, 0);
    endtask

    task automatic load_loop_jmp();
        clear_prog();
        put(0, OP_SET, MOV_X, 3);
        put(1, OP_PUSH_PULL, PUSH_BLK, 0);
        put(2, OP_JMP, COND_X_DEC, 1);
        put(3, OP_PUSH_PULL, PUSH_BLK, 0);
        put(4, OP_JMP, COND_X_ZERO, 30);
        put(5, OP_SET, MOV_X, 0);
        put(6, OP_JMP, COND_X_ZERO, 8);
        put(7, OP_SET, MOV_X, 9);
        put(8, OP_SET, MOV_Y, 0);
        put(9, OP_JMP, COND_Y_ZERO, 11);
        put(10, OP_SET, MOV_X, 13);
        put(11, OP_JMP, COND_X_NE_Y, 30);
        put(12, OP_SET, MOV_Y, 4);
        put(13, OP_JMP, COND_X_NE_Y, 15);
        put(14, OP_SET, MOV_X, 25);
        put(15, OP_JMP, COND_Y_DEC, 15);
        put(16, OP_PUSH_PULL, PUSH_BLK, 0);
        put(17, OP_MOV, MOV_X, MOV_Y);
        put(18, OP_PUSH_PULL, PUSH_BLK, 0);
        put(19, OP_JMP, COND_OSR_NOT_EMPTY, 30);
        put(20, OP_JMP, COND_PIN, 30);
    endtask

    task automatic load_out_fields();
        clear_prog();
        put(0, OP_PUSH_PULL, PULL_BLK, 0);
        put(1, OP_OUT, OUT_X, 8);
        put(2, OP_PUSH_PULL, PUSH_BLK, 0);
        put(3, OP_OUT, OUT_Y, 8);
        put(4, OP_MOV, MOV_X, MOV_Y);
        put(5, OP_PUSH_PULL, PUSH_BLK, 0);
        put(6, OP_JMP, COND_OSR_NOT_EMPTY, 8);
        put(7, OP_SET, MOV_X, 1);
        put(8, OP_OUT, OUT_NULL, 8);
        put(9, OP_OUT, OUT_X, 8);
        put(10, OP_PUSH_PULL, PUSH_BLK, 0);
        put(11, OP_JMP, COND_OSR_NOT_EMPTY, 30);
        put(12, OP_PUSH_PULL, PULL_BLK, 0);
        put(13, OP_OUT, OUT_Y, 0);
        put(14, OP_MOV, MOV_X, MOV_Y);
        put(15, OP_PUSH_PULL, PUSH_BLK, 0);
        put(16, OP_JMP, COND_OSR_NOT_EMPTY, 30);
        put(17, OP_PUSH_PULL, PULL_BLK, 0);
        put(18, OP_MOV, MOV_X, MOV_OSR);
        put(19, OP_PUSH_PULL, PUSH_BLK, 0);
    endtask

    task automatic load_pull_stall();
        clear_prog();
        put(0, OP_SET, MOV_X, 21);
        put(1, OP_PUSH_PULL, PULL_NB, 0);
        put(2, OP_SET, MOV_X, 0);
        put(3, OP_MOV, MOV_X, MOV_OSR);
        put(4, OP_PUSH_PULL, PUSH_BLK, 0);
        put(5, OP_PUSH_PULL, PULL_BLK, 0);
        put(6, OP_MOV, MOV_X, MOV_OSR);
        put(7, OP_PUSH_PULL, PUSH_BLK, 0);
        put(8, OP_OUT, OUT_X, 4);
        put(9, OP_PUSH_PULL, PUSH_BLK, 0);
    endtask

    task automatic load_push_backpressure();
        clear_prog();
        put(0, OP_SET, MOV_X, 11);
        put(1, OP_PUSH_PULL, PUSH_NB, 0);
        put(2, OP_SET, MOV_X, 12);
        put(3, OP_PUSH_PULL, PUSH_BLK, 0);
        put(4, OP_PUSH_PULL, PULL_BLK, 0);
        put(5, OP_MOV, MOV_X, MOV_OSR);
        put(6, OP_PUSH_PULL, PUSH_NB, 0);
        put(7, OP_PUSH_PULL, PULL_BLK, 0);
        put(8, OP_MOV, MOV_X, MOV_OSR);
        put(9, OP_PUSH_PULL, PUSH_BLK, 0);
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        // Start cycle 1000 means that source stays idle
        load_set_mov();
        run_test("set_mov", 80, 5'd16, 1'b0, 1000, 0, 0, 3);
        load_loop_jmp();
        run_test("loop_jmp", 100, 5'd21, 1'b0, 1000, 0, 0, 3);
        load_out_fields();
        run_test("out_shift_left", 100, 5'd20, 1'b0, 0, 4, 0, 3);
        run_test("out_shift_right", 100, 5'd20, 1'b1, 0, 4, 0, 3);
        load_pull_stall();
        run_test("pull_stall", 100, 5'd10, 1'b1, 20, 2, 0, 3);
        load_push_backpressure();
        run_test("push_backpressure", 80, 5'd10, 1'b0, 0, 4, 24, 4);

        $display("Summary: %0d tests, %0d failed, %0d errors",
                 tests_run, tests_failed, total_errors);
        if (total_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
